// ==== pm_consts.svh ====
`ifndef PM_CONSTS_SVH
`define PM_CONSTS_SVH

// one-shot widths in clocks
`define PM_PC_TICKS 1
`define PM_KC_TICKS 2

// PC, strobe 1, strobe 2, KC
`define PM_CYCLE_CLKS (`PM_PC_TICKS + 2 + `PM_KC_TICKS)

// instruction word fields
`define PM_OP_MSB 15
`define PM_OP_LSB 13
`define PM_B_BIT 6
`define PM_C_MSB 2
`define PM_C_LSB 0

// step counter
`define PM_LK_MSB 3
`define PM_LK_LSB 0
`define PM_LK_W 4

`endif

// ==== pm_pkg.sv ====
package pm_pkg;

	// main loop states
	typedef enum logic [2:0] {
		P0 = 3'd0,
		P1 = 3'd1,
		P2 = 3'd2,
		P3 = 3'd3,
		P4 = 3'd4,
		P5 = 3'd5,
		PI = 3'd6
	} pm_state_e;

	// opcode class in ir[15:13], codes 4..7 behave as register ops
	typedef enum logic [2:0] {
		OP_REG = 3'd0,
		OP_ARG = 3'd1,
		OP_GRP = 3'd2,
		OP_HLT = 3'd3
	} pm_op_e;

endpackage

// ==== cycle_if.sv ====
`timescale 1ns/1ps

interface cycle_if;

	// cycle start pulse
	logic pc;
	logic strob1;
	logic strob2;
	// cycle end pulse
	logic kc;

	modport timer (
		output pc,
		output strob1,
		output strob2,
		output kc
	);

	modport ctl (
		input pc,
		input strob1,
		input strob2,
		input kc
	);

endinterface

// ==== univib.sv ====
`timescale 1ns/1ps

module univib #(
	parameter int ticks = 1
) (
	input  logic __clk,
	input  logic rst_n,
	input  logic trig,
	output logic q
);

	localparam int CW = $clog2(ticks + 1);

	logic [CW-1:0] cnt;

	// a trigger seen while the pulse runs is dropped
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else if (trig) begin
			cnt <= CW'(ticks);
		end
	end

	// pulse starts the clock after the trigger
	assign q = (cnt != '0);

endmodule

// ==== cycle_timer.sv ====
`timescale 1ns/1ps
`include "pm_consts.svh"

module cycle_timer (
	input  logic   __clk,
	input  logic   rst_n,
	input  logic   cycle_go,
	cycle_if.timer cyc
);

	localparam int KW = $clog2(`PM_KC_TICKS + 1);

	logic pc_trig;
	logic pc_d;
	logic s2_q;
	logic [KW-1:0] kc_n;
	logic kc_last;
	logic busy;

	univib #(.ticks(`PM_PC_TICKS)) vib_pc (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig(pc_trig),
		.q(cyc.pc)
	);

	// KC is fired by strobe 2
	univib #(.ticks(`PM_KC_TICKS)) vib_kc (
		.__clk(__clk),
		.rst_n(rst_n),
		.trig(s2_q),
		.q(cyc.kc)
	);

	// phase register: PC delayed, strobe 2, KC clocks seen
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			pc_d <= 1'b0;
			s2_q <= 1'b0;
			kc_n <= '0;
		end else begin
			pc_d <= cyc.pc;
			s2_q <= cyc.strob1;
			if (cyc.kc && !kc_last) begin
				kc_n <= kc_n + 1'b1;
			end else begin
				kc_n <= '0;
			end
		end
	end

	// strobe 1 is the clock right after PC falls
	assign cyc.strob1 = pc_d & ~cyc.pc;
	assign cyc.strob2 = s2_q;

	assign kc_last = cyc.kc && (kc_n == KW'(`PM_KC_TICKS - 1));
	assign busy = cyc.pc | cyc.strob1 | cyc.strob2 | cyc.kc;

	// start from idle, or chain onto the last KC clock with no gap
	assign pc_trig = cycle_go & (~busy | kc_last);

endmodule

// ==== lk.sv ====
`timescale 1ns/1ps
`include "pm_consts.svh"

module lk (
	input  logic                 __clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  logic                 dec,
	input  logic [`PM_LK_W-1:0]  value,
	output logic                 zero
);

	logic [`PM_LK_W-1:0] cnt;

	// load wins over count down
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= value;
		end else if (dec && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	// holds at zero once reached
	assign zero = (cnt == '0);

endmodule

// ==== pm.sv ====
`timescale 1ns/1ps
`include "pm_consts.svh"

module pm (
	input  logic              __clk,
	input  logic              rst_n,
	input  logic              start_req,
	input  logic              stop_req,
	input  logic              irq,
	input  logic [15:0]       rdt,
	cycle_if.ctl              cyc,
	output logic              cycle_go,
	output logic              fetch,
	output logic              irq_ack,
	output logic              run,
	output logic              start,
	output logic              wait_,
	output pm_pkg::pm_state_e state
);

	localparam int KW = $clog2(`PM_KC_TICKS + 1);

	logic start_ff;
	logic wait_ff;
	logic stop_pend;
	logic [15:0] ir;
	logic [KW-1:0] kc_n;
	logic kc_last;
	logic wake;
	logic lk_load;
	logic lk_dec;
	logic [`PM_LK_W-1:0] lk_value;
	logic lk_zero;
	logic lk_was_zero;
	logic end_stop;
	logic end_halt;
	logic b_mod;
	logic c_zero;
	pm_pkg::pm_op_e op;
	pm_pkg::pm_state_e state_nx;

	lk cnt_lk (
		.__clk(__clk),
		.rst_n(rst_n),
		.load(lk_load),
		.dec(lk_dec),
		.value(lk_value),
		.zero(lk_zero)
	);

	// opcode class
	always_comb begin
		case (ir[`PM_OP_MSB:`PM_OP_LSB])
			pm_pkg::OP_ARG: op = pm_pkg::OP_ARG;
			pm_pkg::OP_GRP: op = pm_pkg::OP_GRP;
			pm_pkg::OP_HLT: op = pm_pkg::OP_HLT;
			default: op = pm_pkg::OP_REG;
		endcase
	end

	assign b_mod = ir[`PM_B_BIT];
	assign c_zero = (ir[`PM_C_MSB:`PM_C_LSB] == '0);

	// count KC clocks to find the last one
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			kc_n <= '0;
		end else if (cyc.kc && !kc_last) begin
			kc_n <= kc_n + 1'b1;
		end else begin
			kc_n <= '0;
		end
	end

	assign kc_last = cyc.kc && (kc_n == KW'(`PM_KC_TICKS - 1));

	// next state is taken at the end of the cycle
	always_comb begin
		state_nx = state;
		end_stop = 1'b0;
		end_halt = 1'b0;
		case (state)
			pm_pkg::P0: begin
				if (start_ff) state_nx = pm_pkg::P1;
			end
			pm_pkg::P1: begin
				if (op != pm_pkg::OP_ARG) state_nx = pm_pkg::P5;
				else if (c_zero) state_nx = pm_pkg::P2;
				else if (b_mod) state_nx = pm_pkg::P3;
				else state_nx = pm_pkg::P4;
			end
			pm_pkg::P2: begin
				state_nx = b_mod ? pm_pkg::P3 : pm_pkg::P4;
			end
			pm_pkg::P3: state_nx = pm_pkg::P4;
			pm_pkg::P4: state_nx = pm_pkg::P5;
			pm_pkg::P5: begin
				if ((op == pm_pkg::OP_GRP) && !lk_was_zero) begin
					state_nx = pm_pkg::P5;
				end else if (stop_pend) begin
					state_nx = pm_pkg::P0;
					end_stop = 1'b1;
				end else if (irq) begin
					state_nx = pm_pkg::PI;
				end else if (op == pm_pkg::OP_HLT) begin
					// parked in PI until irq wakes the unit
					state_nx = pm_pkg::PI;
					end_halt = 1'b1;
				end else begin
					state_nx = pm_pkg::P1;
				end
			end
			pm_pkg::PI: state_nx = pm_pkg::P1;
			default: state_nx = pm_pkg::P0;
		endcase
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= pm_pkg::P0;
		end else if (kc_last) begin
			state <= state_nx;
		end
	end

	// START, WAIT and stop request
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			start_ff <= 1'b0;
			wait_ff <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			if (kc_last && end_stop) begin
				start_ff <= 1'b0;
			end else if (start_req && (state == pm_pkg::P0)) begin
				start_ff <= 1'b1;
			end
			if (kc_last && end_halt) begin
				wait_ff <= 1'b1;
			end else if (wake) begin
				wait_ff <= 1'b0;
			end
			if (kc_last && end_stop) begin
				stop_pend <= 1'b0;
			end else if (stop_req && run) begin
				stop_pend <= 1'b1;
			end
		end
	end

	// lk zero as seen on strobe 2 of P5
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			lk_was_zero <= 1'b0;
		end else if (cyc.strob2 && (state == pm_pkg::P5)) begin
			lk_was_zero <= lk_zero;
		end
	end

	always_ff @(posedge __clk) begin
		if (fetch) begin
			ir <= rdt;
		end
	end

	assign wake = wait_ff & irq;
	assign run = start_ff & ~wait_ff;
	assign start = start_ff;
	assign wait_ = ~wait_ff;
	// the halting cycle chains no successor
	assign cycle_go = (run & ~(kc_last & end_halt)) | wake | stop_pend;

	assign fetch = cyc.strob1 && (state == pm_pkg::P1);
	assign irq_ack = cyc.strob2 && (state == pm_pkg::PI);

	// step count comes from the word fetched in P1
	assign lk_value = ir[`PM_LK_MSB:`PM_LK_LSB];
	assign lk_load = cyc.strob2 && (state == pm_pkg::P1) && (op == pm_pkg::OP_GRP);
	assign lk_dec = cyc.strob2 && (state == pm_pkg::P5) && (op == pm_pkg::OP_GRP);

endmodule

// ==== pm_unit.sv ====
`timescale 1ns/1ps

module pm_unit (
	input  logic        __clk,
	input  logic        rst_n,
	input  logic        start_req,
	input  logic        stop_req,
	input  logic        irq,
	input  logic [15:0] rdt,
	output logic [2:0]  state,
	output logic        kc,
	output logic        fetch,
	output logic        irq_ack,
	output logic        run,
	output logic        start,
	output logic        wait_
);

	logic cycle_go;

	cycle_if cyc ();

	cycle_timer u_timer (
		.__clk(__clk),
		.rst_n(rst_n),
		.cycle_go(cycle_go),
		.cyc(cyc.timer)
	);

	pm u_pm (
		.__clk(__clk),
		.rst_n(rst_n),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.rdt(rdt),
		.cyc(cyc.ctl),
		.cycle_go(cycle_go),
		.fetch(fetch),
		.irq_ack(irq_ack),
		.run(run),
		.start(start),
		.wait_(wait_),
		.state(state)
	);

	assign kc = cyc.kc;

endmodule

// ==== pm_assertions.sv ====
`timescale 1ns/1ps

module pm_assertions (
	input logic       __clk,
	input logic       rst_n,
	input logic       pc,
	input logic       strob1,
	input logic       strob2,
	input logic       kc,
	input logic       irq_ack,
	input logic       run,
	input logic       wait_,
	input logic [2:0] state
);

	// at most one timing strobe per clock
	a_strobes: assert property (@(posedge __clk) disable iff (!rst_n)
		$onehot0({pc, strob1, strob2, kc}))
		else $error("cycle strobes overlap");

	// state moves only after the last KC clock
	a_state_kc: assert property (@(posedge __clk) disable iff (!rst_n)
		(state != $past(state)) |-> ($past(kc) && !kc))
		else $error("state changed outside the last KC clock");

	// leaving PI means the cycle acknowledged the irq
	a_ack_pi: assert property (@(posedge __clk) disable iff (!rst_n)
		((state != pm_pkg::PI) && ($past(state) == pm_pkg::PI)) |-> $past(irq_ack, 3))
		else $error("PI cycle ended without irq_ack");

	// a waiting machine neither runs nor strobes
	a_run_wait: assert property (@(posedge __clk) disable iff (!rst_n)
		!wait_ |-> (!run && !strob1))
		else $error("cycle activity while waiting");

endmodule

bind pm pm_assertions u_assert (
	.__clk(__clk),
	.rst_n(rst_n),
	.pc(cyc.pc),
	.strob1(cyc.strob1),
	.strob2(cyc.strob2),
	.kc(cyc.kc),
	.irq_ack(irq_ack),
	.run(run),
	.wait_(wait_),
	.state(state)
);

// ==== tb_pm_unit.sv ====
`timescale 1ns/1ps
`include "pm_consts.svh"

module tb_pm_unit;

	localparam int NROWS = 12;
	localparam int IDLE_NONE = 0;
	localparam int IDLE_HALT = 1;
	localparam int IDLE_STOP = 2;
	// bits 12..7 and 5..4 are never decoded
	localparam logic [15:0] FILL_MASK = 16'h1FB0;

	// kick, word, irq at end, stop, states as hex digits left to right, length, P5 count, idle
	typedef struct packed {
		bit kick;
		logic [15:0] word;
		bit irq_end;
		bit stop;
		logic [31:0] seq;
		int len;
		int reps;
		int idle;
	} row_t;

	logic __clk;
	logic rst_n;
	logic start_req;
	logic stop_req;
	logic irq;
	logic [15:0] rdt;
	logic [2:0] state;
	logic kc;
	logic fetch;
	logic irq_ack;
	logic run;
	logic start;
	logic wait_;

	row_t tbl [NROWS];
	integer seed = 67;
	int errors = 0;
	int checks = 0;
	int clocks = 0;
	int limit = 1000000;
	int gap = 0;
	bit chained = 1'b0;
	bit kc_prev = 1'b0;
	bit fetch_prev = 1'b0;
	bit kc_rise;
	bit fetch_rise;

	pm_unit DUT (.*);

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk;
	end

	always @(posedge __clk) begin
		clocks++;
		if (clocks >= limit) begin
			$display("timeout: run went past %0d clocks", limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got=%0h exp=%0h", name, got, exp);
		end
	endtask

	function automatic logic [15:0] fill_word(input logic [15:0] w);
		return (w & ~FILL_MASK) | (16'($random(seed)) & FILL_MASK);
	endfunction

	// i-th state of a row counting from the left digit
	function automatic logic [2:0] seq_at(input int r, input int i);
		return tbl[r].seq[(tbl[r].len - 1 - i) * 4 +: 3];
	endfunction

	task automatic step();
		@(negedge __clk);
		kc_rise = kc & ~kc_prev;
		fetch_rise = fetch & ~fetch_prev;
		kc_prev = kc;
		fetch_prev = fetch;
		gap++;
	endtask

	task automatic run_row(input int r);
		logic [2:0] exp_q[$];
		int n_fetch = 0;
		int n_ack = 0;
		int fetch_exp = 0;
		int ack_exp = 0;
		int idx = 0;
		for (int i = 0; i < tbl[r].len; i++) begin
			if (seq_at(r, i) == pm_pkg::P5)
				repeat (tbl[r].reps) exp_q.push_back(pm_pkg::P5);
			else
				exp_q.push_back(seq_at(r, i));
			fetch_exp += (seq_at(r, i) == pm_pkg::P1);
			ack_exp += (seq_at(r, i) == pm_pkg::PI);
		end
		if (tbl[r].kick) begin
			start_req = 1'b1;
			step();
			start_req = 1'b0;
			check_val("start", start, 1);
		end
		while (idx < exp_q.size()) begin
			step();
			stop_req = 1'b0;
			if (fetch_rise) begin
				n_fetch++;
				rdt = fill_word(tbl[r].word);
				irq = tbl[r].irq_end;
				stop_req = tbl[r].stop;
			end
			if (irq_ack) begin
				n_ack++;
				irq = 1'b0;
			end
			if (kc_rise) begin
				if (chained)
					check_val("kc_gap", gap, `PM_CYCLE_CLKS);
				chained = 1'b1;
				gap = 0;
				check_val("state", state, exp_q[idx]);
				idx++;
			end
		end
		if (n_fetch != fetch_exp) begin
			errors++;
			$display("row %0d: expected %0d fetch pulses but saw %0d", r, fetch_exp, n_fetch);
		end
		check_val("irq_ack_count", n_ack, ack_exp);
	endtask

	// no cycle may start while halted or stopped
	task automatic expect_idle(input logic [2:0] exp_state);
		int rises = 0;
		repeat (4 * `PM_CYCLE_CLKS) begin
			step();
			rises += kc_rise;
		end
		if (rises != 0) begin
			errors++;
			$display("machine cycles kept running while the unit should be idle");
		end
		chained = 1'b0;
		check_val("run", run, 0);
		check_val("state", state, exp_state);
	endtask

	initial begin
		int total;
		rst_n = 1'b0;
		start_req = 1'b0;
		stop_req = 1'b0;
		irq = 1'b0;
		rdt = '0;
		tbl[0] = '{1'b1, 16'h0000, 1'b0, 1'b0, 32'h015, 3, 1, IDLE_NONE};
		tbl[1] = '{1'b0, 16'h2040, 1'b0, 1'b0, 32'h12345, 5, 1, IDLE_NONE};
		tbl[2] = '{1'b0, 16'h2005, 1'b0, 1'b0, 32'h145, 3, 1, IDLE_NONE};
		tbl[3] = '{1'b0, 16'h4000, 1'b0, 1'b0, 32'h15, 2, 1, IDLE_NONE};
		tbl[4] = '{1'b0, 16'h4003, 1'b0, 1'b0, 32'h15, 2, 4, IDLE_NONE};
		tbl[5] = '{1'b0, 16'h400F, 1'b0, 1'b0, 32'h15, 2, 16, IDLE_NONE};
		tbl[6] = '{1'b0, 16'h0000, 1'b1, 1'b0, 32'h156, 3, 1, IDLE_NONE};
		tbl[7] = '{1'b0, 16'h6000, 1'b0, 1'b0, 32'h15, 2, 1, IDLE_HALT};
		// wake-up cycle comes first
		tbl[8] = '{1'b0, 16'h0000, 1'b0, 1'b0, 32'h615, 3, 1, IDLE_NONE};
		tbl[9] = '{1'b0, 16'h0005, 1'b0, 1'b1, 32'h150, 3, 1, IDLE_STOP};
		tbl[10] = '{1'b1, 16'h2001, 1'b0, 1'b0, 32'h0145, 4, 1, IDLE_NONE};
		// opcode 5 falls back to a register op
		tbl[11] = '{1'b0, 16'hA000, 1'b0, 1'b0, 32'h15, 2, 1, IDLE_NONE};
		total = 0;
		for (int r = 0; r < NROWS; r++)
			total += tbl[r].len + tbl[r].reps - 1;
		limit = total * `PM_CYCLE_CLKS * 2 + 200;
		repeat (4) @(negedge __clk);
		rst_n = 1'b1;
		step();
		check_val("state", state, pm_pkg::P0);
		check_val("run", run, 0);
		check_val("start", start, 0);
		check_val("kc", kc, 0);
		check_val("fetch", fetch, 0);
		check_val("irq_ack", irq_ack, 0);
		check_val("wait_", wait_, 1);
		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
			if (tbl[r].idle == IDLE_HALT) begin
				expect_idle(pm_pkg::PI);
				check_val("wait_", wait_, 0);
				irq = 1'b1;
				for (int i = 0; i < 10 && !wait_; i++)
					step();
				if (!wait_) begin
					errors++;
					$display("irq did not release the halted unit");
				end
				irq = 1'b0;
			end else if (tbl[r].idle == IDLE_STOP) begin
				expect_idle(pm_pkg::P0);
				check_val("start", start, 0);
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
pm_pkg.sv
cycle_if.sv
univib.sv
cycle_timer.sv
lk.sv
pm.sv
pm_unit.sv
pm_assertions.sv
tb_pm_unit.sv
